//--- common/rx_buf_pkg.sv
// rx interleaving buffer shared definitions
// sizes, FSM and word-select enums, and the structs passed between blocks
`default_nettype none

package rx_buf_pkg;

	//////////////////////////////
	// sizes
	//////////////////////////////
	localparam int RX_CHANS       = 4;     // receive channels
	localparam int SAMP_BITS      = 24;    // one I or Q sample
	localparam int WORD_BITS      = 16;    // ram word
	localparam int TICKS_BITS     = 48;    // timestamp
	localparam int NSAMPS_BITS    = 8;     // groups per block
	localparam int RXBUF_DEPTH    = 1024;  // ram words
	localparam int RXBUF_AW       = 10;
	localparam int WORDS_PER_CHAN = 3;     // i hi, q hi, iq low bytes
	localparam int TRAILER_WORDS  = 4;     // 3 ticks words + buffer counter
	localparam int CHAN_BITS      = $clog2(RX_CHANS);
	localparam int GROUP_WORDS    = RX_CHANS * WORDS_PER_CHAN;
	localparam int NEED_BITS      = NSAMPS_BITS + 5;  // holds nsamps*12+4

	typedef logic [CHAN_BITS-1:0]   chan_idx_t;
	typedef logic [1:0]             phase_t;      // word phase within a channel
	typedef logic [NSAMPS_BITS-1:0] nsamps_t;
	typedef logic [RXBUF_AW:0]      free_cnt_t;   // 0..RXBUF_DEPTH
	typedef logic [NEED_BITS-1:0]   need_cnt_t;
	typedef logic [WORD_BITS-1:0]   rx_word_t;    // read stream data

	//////////////////////////////
	// enums
	//////////////////////////////
	typedef enum logic [2:0] {
		XFER_IDLE,       // waiting for the first strobe of a block
		XFER_CHAN,       // writing channel words
		XFER_GROUP_END,  // group written, waiting for next strobe
		XFER_TICKS,      // timestamp words
		XFER_BUF_CTR,    // block counter word
		XFER_DONE
	} xfer_state_e;

	typedef enum logic [2:0] {
		SEL_I,
		SEL_Q,
		SEL_IQ_LOW,
		SEL_TICKS_LO,
		SEL_TICKS_MID,
		SEL_TICKS_HI,
		SEL_BUF_CTR
	} word_sel_e;

	//////////////////////////////
	// structs
	//////////////////////////////
	typedef struct packed {
		logic signed [SAMP_BITS-1:0] i;
		logic signed [SAMP_BITS-1:0] q;
	} iq_samp_t;

	typedef iq_samp_t [RX_CHANS-1:0] chan_samps_t;  // channel 0 in the low bits

	typedef struct packed {
		logic      we;
		word_sel_e sel;
		chan_idx_t chan;
	} word_req_t;

	typedef struct packed {
		logic     we;
		rx_word_t data;
	} ram_wr_t;

endpackage

`default_nettype wire

//--- rx_buffer/rx_group_counter.sv
// rx group counter
// nested word phase, channel and sample group counters for one block
`timescale 1ns/10ps
`default_nettype none

module rx_group_counter (
	input  logic                  adc_clk,
	input  logic                  reset_bufs_A,
	input  logic                  clear_i,
	input  logic                  step_i,
	input  logic                  start_block_i,
	input  rx_buf_pkg::nsamps_t   nsamps_i,
	output rx_buf_pkg::phase_t    phase_o,
	output rx_buf_pkg::chan_idx_t chan_o,
	output logic                  group_end_o,
	output logic                  last_group_o
);

	rx_buf_pkg::phase_t    phase_q;
	rx_buf_pkg::chan_idx_t chan_q;
	rx_buf_pkg::nsamps_t   group_q, nsamps_q;
	logic                  phase_wrap, chan_wrap;

	assign phase_wrap = (phase_q == rx_buf_pkg::phase_t'(rx_buf_pkg::WORDS_PER_CHAN - 1));
	assign chan_wrap = (chan_q == rx_buf_pkg::chan_idx_t'(rx_buf_pkg::RX_CHANS - 1));

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			phase_q <= '0;
			chan_q <= '0;
			group_q <= '0;
			nsamps_q <= '0;
		end
		else
		begin
			if (start_block_i)
				nsamps_q <= nsamps_i;  // held for the whole block
			if (clear_i)
			begin
				phase_q <= '0;
				chan_q <= '0;
				group_q <= '0;
			end
			else if (step_i)
			begin
				phase_q <= phase_wrap ? '0 : phase_q + 1'b1;
				if (phase_wrap)
				begin
					chan_q <= chan_wrap ? '0 : chan_q + 1'b1;
					if (chan_wrap)
						group_q <= last_group_o ? '0 : group_q + 1'b1;
				end
			end
		end
	end

	assign phase_o = phase_q;
	assign chan_o = chan_q;
	assign group_end_o = phase_wrap && chan_wrap;  // iq low word of last channel
	assign last_group_o = (group_q == nsamps_q - rx_buf_pkg::nsamps_t'(1));

endmodule

`default_nettype wire

//--- rx_buffer/rx_xfer_fsm.sv
// rx transfer FSM
// sequences channel words per strobe, then ticks and block counter words on the last group
`timescale 1ns/10ps
`default_nettype none

module rx_xfer_fsm (
	input  logic                    adc_clk,
	input  logic                    reset_bufs_A,
	input  logic                    samp_avail_i,
	input  rx_buf_pkg::free_cnt_t   free_words_i,
	input  rx_buf_pkg::nsamps_t     nsamps_i,
	input  rx_buf_pkg::phase_t      phase_i,
	input  rx_buf_pkg::chan_idx_t   chan_i,
	input  logic                    group_end_i,
	input  logic                    last_group_i,
	output logic                    cnt_clear_o,
	output logic                    cnt_step_o,
	output logic                    start_block_o,
	output logic                    latch_o,
	output rx_buf_pkg::word_req_t   word_req_o,
	output logic                    block_done_o,
	output logic                    overrun_o
);

	rx_buf_pkg::xfer_state_e state_q, state_d;
	rx_buf_pkg::need_cnt_t   need_words;
	rx_buf_pkg::word_req_t   req_d;
	rx_buf_pkg::word_sel_e   chan_sel, ticks_sel;
	logic                    room, accept, done_pend_q;

	// whole block must fit before it is started
	assign need_words = rx_buf_pkg::need_cnt_t'(nsamps_i) *
		rx_buf_pkg::need_cnt_t'(rx_buf_pkg::GROUP_WORDS) +
		rx_buf_pkg::need_cnt_t'(rx_buf_pkg::TRAILER_WORDS);
	assign room = need_words <= rx_buf_pkg::need_cnt_t'(free_words_i);

	assign start_block_o = samp_avail_i && room && (state_q == rx_buf_pkg::XFER_IDLE);
	assign accept = start_block_o || (samp_avail_i && (state_q == rx_buf_pkg::XFER_GROUP_END));
	assign cnt_step_o = accept || (state_q == rx_buf_pkg::XFER_CHAN) ||
		(state_q == rx_buf_pkg::XFER_TICKS);
	assign cnt_clear_o = (state_q == rx_buf_pkg::XFER_DONE);  // counter back to 0 for next block

	always_comb
	begin
		case (phase_i)  // word within a channel
			2'd0:    chan_sel = rx_buf_pkg::SEL_I;
			2'd1:    chan_sel = rx_buf_pkg::SEL_Q;
			default: chan_sel = rx_buf_pkg::SEL_IQ_LOW;
		endcase
		case (phase_i)  // ticks go out low word first
			2'd0:    ticks_sel = rx_buf_pkg::SEL_TICKS_LO;
			2'd1:    ticks_sel = rx_buf_pkg::SEL_TICKS_MID;
			default: ticks_sel = rx_buf_pkg::SEL_TICKS_HI;
		endcase
	end

	always_comb
	begin
		state_d = state_q;
		req_d = '0;  // no write
		case (state_q)
			rx_buf_pkg::XFER_IDLE, rx_buf_pkg::XFER_GROUP_END:
				if (accept)
				begin
					state_d = rx_buf_pkg::XFER_CHAN;
					req_d = '{we: 1'b1, sel: chan_sel, chan: chan_i};  // first word i hi of ch0
				end
			rx_buf_pkg::XFER_CHAN:
			begin
				req_d = '{we: 1'b1, sel: chan_sel, chan: chan_i};
				if (group_end_i)  // last word of last channel
					state_d = last_group_i ? rx_buf_pkg::XFER_TICKS : rx_buf_pkg::XFER_GROUP_END;
			end
			rx_buf_pkg::XFER_TICKS:
			begin
				req_d = '{we: 1'b1, sel: ticks_sel, chan: '0};
				if (phase_i == 2'd2)
					state_d = rx_buf_pkg::XFER_BUF_CTR;
			end
			rx_buf_pkg::XFER_BUF_CTR:
			begin
				req_d = '{we: 1'b1, sel: rx_buf_pkg::SEL_BUF_CTR, chan: '0};
				state_d = rx_buf_pkg::XFER_DONE;
			end
			default:
				state_d = rx_buf_pkg::XFER_IDLE;  // DONE
		endcase
	end

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			state_q <= rx_buf_pkg::XFER_IDLE;
			word_req_o <= '0;
			latch_o <= 1'b0;
			done_pend_q <= 1'b0;
			block_done_o <= 1'b0;
			overrun_o <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			word_req_o <= req_d;
			latch_o <= accept;  // capture inputs the cycle after the strobe
			// ctr word is written two cycles after DONE, done pulses one later
			done_pend_q <= (state_q == rx_buf_pkg::XFER_DONE);
			block_done_o <= done_pend_q;
			if (samp_avail_i && !room && (state_q == rx_buf_pkg::XFER_IDLE))
				overrun_o <= 1'b1;  // refused block, sticky
		end
	end

endmodule

`default_nettype wire

//--- rx_buffer/rx_word_select.sv
// rx word select
// latches samples and ticks, keeps the block counter, registers each ram write word
`timescale 1ns/10ps
`default_nettype none

module rx_word_select (
	input  logic                    adc_clk,
	input  logic                    reset_bufs_A,
	input  logic                    latch_i,
	input  rx_buf_pkg::chan_samps_t chan_samps_i,
	input  logic [rx_buf_pkg::TICKS_BITS-1:0] ticks_i,
	input  logic                    block_done_i,
	input  rx_buf_pkg::word_req_t   word_req_i,
	output rx_buf_pkg::ram_wr_t     ram_wr_o
);

	rx_buf_pkg::chan_samps_t samps_q, samp_src;
	rx_buf_pkg::iq_samp_t    cur;
	logic [rx_buf_pkg::TICKS_BITS-1:0] ticks_q;
	rx_buf_pkg::rx_word_t    buf_ctr_q, word_d, wr_data_q;
	logic                    wr_en_q;

	// sample and timestamp hold
	always_ff @(posedge adc_clk)
	begin
		if (latch_i)
		begin
			samps_q <= chan_samps_i;
			ticks_q <= ticks_i;
		end
	end

	// first word of a group is formed while the latch loads, so take it from the inputs
	assign samp_src = latch_i ? chan_samps_i : samps_q;
	assign cur = samp_src[word_req_i.chan];

	always_comb
	begin
		case (word_req_i.sel)
			rx_buf_pkg::SEL_I:         word_d = cur.i[rx_buf_pkg::SAMP_BITS-1 -: rx_buf_pkg::WORD_BITS];
			rx_buf_pkg::SEL_Q:         word_d = cur.q[rx_buf_pkg::SAMP_BITS-1 -: rx_buf_pkg::WORD_BITS];
			rx_buf_pkg::SEL_IQ_LOW:    word_d = {cur.i[7:0], cur.q[7:0]};  // i low byte on top
			rx_buf_pkg::SEL_TICKS_LO:  word_d = ticks_q[15:0];
			rx_buf_pkg::SEL_TICKS_MID: word_d = ticks_q[31:16];
			rx_buf_pkg::SEL_TICKS_HI:  word_d = ticks_q[47:32];
			rx_buf_pkg::SEL_BUF_CTR:   word_d = buf_ctr_q;
			default:                   word_d = '0;
		endcase
	end

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			buf_ctr_q <= '0;
			wr_en_q <= 1'b0;
		end
		else
		begin
			if (block_done_i)
				buf_ctr_q <= buf_ctr_q + 1'b1;  // blocks completed so far
			wr_en_q <= word_req_i.we;
		end
	end

	always_ff @(posedge adc_clk)
	begin
		wr_data_q <= word_d;
	end

	assign ram_wr_o = '{we: wr_en_q, data: wr_data_q};

endmodule

`default_nettype wire

//--- rx_buffer/rx_sample_ram.sv
// rx sample ram
// circular word memory with fill tracking and a one-word valid/ready output stage
`timescale 1ns/10ps
`default_nettype none

module rx_sample_ram (
	input  logic                  adc_clk,
	input  logic                  reset_bufs_A,
	input  rx_buf_pkg::ram_wr_t   ram_wr_i,
	output rx_buf_pkg::free_cnt_t free_words_o,
	output logic                  rd_valid_o,
	output rx_buf_pkg::rx_word_t  rd_data_o,
	input  logic                  rd_ready_i
);

	rx_buf_pkg::rx_word_t  mem [rx_buf_pkg::RXBUF_DEPTH];
	rx_buf_pkg::free_cnt_t wptr_q, rptr_q;  // one extra bit tells full from empty
	rx_buf_pkg::free_cnt_t fill;
	logic                  load;

	//////////////////////////////
	// write side
	//////////////////////////////
	always_ff @(posedge adc_clk)
	begin
		if (ram_wr_i.we)
			mem[wptr_q[rx_buf_pkg::RXBUF_AW-1:0]] <= ram_wr_i.data;
	end

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
			wptr_q <= '0;
		else if (ram_wr_i.we)
			wptr_q <= wptr_q + 1'b1;  // wraps through the whole ram
	end

	assign fill = wptr_q - rptr_q;  // words in memory, not counting the output stage

	// word in flight this cycle is already spoken for
	assign free_words_o = rx_buf_pkg::free_cnt_t'(rx_buf_pkg::RXBUF_DEPTH) - fill -
		rx_buf_pkg::free_cnt_t'(ram_wr_i.we);

	//////////////////////////////
	// read side
	//////////////////////////////
	// reload when the stage is empty or its word goes out this cycle
	assign load = (fill != '0) && (!rd_valid_o || rd_ready_i);

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			rptr_q <= '0;
			rd_valid_o <= 1'b0;
		end
		else if (load)
		begin
			rptr_q <= rptr_q + 1'b1;
			rd_valid_o <= 1'b1;
		end
		else if (rd_ready_i)
			rd_valid_o <= 1'b0;  // taken and nothing behind it
	end

	always_ff @(posedge adc_clk)
	begin
		if (load)
			rd_data_o <= mem[rptr_q[rx_buf_pkg::RXBUF_AW-1:0]];  // held while stalled
	end

endmodule

`default_nettype wire

//--- design/rx_buffer_top.sv
// rx buffer top
// FSM, group counter, word select and sample ram joined into one stream source
`timescale 1ns/10ps
`default_nettype none

module rx_buffer_top (
	input  logic                    adc_clk,
	input  logic                    reset_bufs_A,
	input  logic                    samp_avail_i,
	input  rx_buf_pkg::chan_samps_t chan_samps_i,
	input  logic [rx_buf_pkg::TICKS_BITS-1:0] ticks_i,
	input  rx_buf_pkg::nsamps_t     nsamps_i,
	input  logic                    rd_ready_i,
	output logic                    rd_valid_o,
	output rx_buf_pkg::rx_word_t    rd_data_o,
	output logic                    block_done_o,
	output logic                    overrun_o
);

	rx_buf_pkg::phase_t    phase;
	rx_buf_pkg::chan_idx_t chan;
	logic                  group_end, last_group;
	logic                  cnt_clear, cnt_step, start_block, latch;
	rx_buf_pkg::word_req_t word_req;
	rx_buf_pkg::ram_wr_t   ram_wr;
	rx_buf_pkg::free_cnt_t free_words;

	rx_group_counter u_counter (
		.adc_clk       (adc_clk),
		.reset_bufs_A  (reset_bufs_A),
		.clear_i       (cnt_clear),
		.step_i        (cnt_step),
		.start_block_i (start_block),
		.nsamps_i      (nsamps_i),
		.phase_o       (phase),
		.chan_o        (chan),
		.group_end_o   (group_end),
		.last_group_o  (last_group)
	);

	rx_xfer_fsm u_fsm (
		.adc_clk       (adc_clk),
		.reset_bufs_A  (reset_bufs_A),
		.samp_avail_i  (samp_avail_i),
		.free_words_i  (free_words),
		.nsamps_i      (nsamps_i),
		.phase_i       (phase),
		.chan_i        (chan),
		.group_end_i   (group_end),
		.last_group_i  (last_group),
		.cnt_clear_o   (cnt_clear),
		.cnt_step_o    (cnt_step),
		.start_block_o (start_block),
		.latch_o       (latch),
		.word_req_o    (word_req),
		.block_done_o  (block_done_o),
		.overrun_o     (overrun_o)
	);

	rx_word_select u_word_sel (
		.adc_clk       (adc_clk),
		.reset_bufs_A  (reset_bufs_A),
		.latch_i       (latch),
		.chan_samps_i  (chan_samps_i),
		.ticks_i       (ticks_i),
		.block_done_i  (block_done_o),  // bumps the block counter
		.word_req_i    (word_req),
		.ram_wr_o      (ram_wr)
	);

	rx_sample_ram u_ram (
		.adc_clk       (adc_clk),
		.reset_bufs_A  (reset_bufs_A),
		.ram_wr_i      (ram_wr),
		.free_words_o  (free_words),
		.rd_valid_o    (rd_valid_o),
		.rd_data_o     (rd_data_o),
		.rd_ready_i    (rd_ready_i)
	);

endmodule

`default_nettype wire

//--- dv/rx_buffer_asserts.sv
// rx buffer protocol assertions
// read stream handshake, reset values and block_done / overrun flag behavior
`timescale 1ns/10ps
`default_nettype none

module rx_buffer_asserts (
	input logic                 adc_clk,
	input logic                 reset_bufs_A,
	input logic                 rd_ready_i,
	input logic                 rd_valid_o,
	input rx_buf_pkg::rx_word_t rd_data_o,
	input logic                 block_done_o,
	input logic                 overrun_o
);

	int hold_fails = 0;
	int valid_fails = 0;
	int reset_fails = 0;
	int done_fails = 0;
	int ovr_fails = 0;
	int fail_cnt;  // total, read by the testbench

	assign fail_cnt = hold_fails + valid_fails + reset_fails + done_fails + ovr_fails;

	//////////////////////////////
	// read stream
	//////////////////////////////
	data_hold: assert property (@(posedge adc_clk) disable iff (reset_bufs_A)
		rd_valid_o && !rd_ready_i |=> $stable(rd_data_o))
	else
	begin
		hold_fails++;
		$error("rd_data_o changed while stalled");
	end

	valid_hold: assert property (@(posedge adc_clk) disable iff (reset_bufs_A)
		rd_valid_o && !rd_ready_i |=> rd_valid_o)  // no drop without a transfer
	else
	begin
		valid_fails++;
		$error("rd_valid_o fell without a transfer");
	end

	//////////////////////////////
	// control outputs
	//////////////////////////////
	reset_low: assert property (@(posedge adc_clk)
		reset_bufs_A |=> !rd_valid_o && !block_done_o && !overrun_o)
	else
	begin
		reset_fails++;
		$error("outputs not cleared by reset");
	end

	done_pulse: assert property (@(posedge adc_clk) disable iff (reset_bufs_A)
		block_done_o |=> !block_done_o)
	else
	begin
		done_fails++;
		$error("block_done_o high for more than one cycle");
	end

	ovr_sticky: assert property (@(posedge adc_clk) disable iff (reset_bufs_A)
		overrun_o |=> overrun_o)
	else
	begin
		ovr_fails++;
		$error("overrun_o dropped without reset");
	end

endmodule

bind rx_buffer_top rx_buffer_asserts u_asserts (
	.adc_clk      (adc_clk),
	.reset_bufs_A (reset_bufs_A),
	.rd_ready_i   (rd_ready_i),
	.rd_valid_o   (rd_valid_o),
	.rd_data_o    (rd_data_o),
	.block_done_o (block_done_o),
	.overrun_o    (overrun_o)
);

`default_nettype wire

//--- dv/tb_rx_buffer.sv
// rx buffer testbench
// random sample groups against a reference word queue, flag checks and a closing report
`timescale 1ns/10ps
`default_nettype none

module tb_rx_buffer;

	localparam int          CLK_HALF   = 2;              // 4 ns period
	localparam logic [31:0] SEED       = 32'h2b1d_9ea6;
	localparam int          WAIT_LIMIT = 5000;           // cycles allowed per wait loop
	localparam int          STROBE_GAP = 20;             // cycles between group strobes

	logic                              adc_clk;
	logic                              reset_bufs_A;
	logic                              samp_avail_i;
	rx_buf_pkg::chan_samps_t           chan_samps_i;
	logic [rx_buf_pkg::TICKS_BITS-1:0] ticks_i;
	rx_buf_pkg::nsamps_t               nsamps_i;
	logic                              rd_ready_i;
	logic                              rd_valid_o;
	rx_buf_pkg::rx_word_t              rd_data_o;
	logic                              block_done_o;
	logic                              overrun_o;

	rx_buf_pkg::rx_word_t exp_q[$];  // words the stream still owes, oldest first
	logic [31:0] samp_rng;
	logic [31:0] rdy_rng;
	int rdy_mode = 0;      // 0 ready high, 1 ready low, 2 random
	int word_errs = 0;     // stream compare, monitor only
	int flag_errs = 0;
	int wait_errs = 0;
	int done_seen = 0;     // block_done_o pulses seen by the monitor
	int exp_done = 0;
	int blocks_done = 0;   // expected counter word, cleared by reset

	rx_buffer_top DUT (
		.adc_clk      (adc_clk),
		.reset_bufs_A (reset_bufs_A),
		.samp_avail_i (samp_avail_i),
		.chan_samps_i (chan_samps_i),
		.ticks_i      (ticks_i),
		.nsamps_i     (nsamps_i),
		.rd_ready_i   (rd_ready_i),
		.rd_valid_o   (rd_valid_o),
		.rd_data_o    (rd_data_o),
		.block_done_o (block_done_o),
		.overrun_o    (overrun_o)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	initial
	begin
		adc_clk = 1'b0;
		forever
			#CLK_HALF adc_clk = ~adc_clk;
	end

	// reader side, ready pattern picked by rdy_mode
	initial
	begin
		rd_ready_i = 1'b1;
		rdy_rng = xorshift(SEED);
		forever
		begin
			@(posedge adc_clk);
			rdy_rng = xorshift(rdy_rng);
			case (rdy_mode)
				0:       rd_ready_i <= 1'b1;
				1:       rd_ready_i <= 1'b0;
				default: rd_ready_i <= rdy_rng[3];
			endcase
		end
	end

	task automatic check_word(input rx_buf_pkg::rx_word_t got, input rx_buf_pkg::rx_word_t exp);
		if (got !== exp)
		begin
			word_errs++;
			$display("FAILED rd_data_o: got %h expected %h", got, exp);
		end
	endtask

	//////////////////////////////
	// stream monitor
	//////////////////////////////
	always @(negedge adc_clk)
	begin
		if (!reset_bufs_A)
		begin
			if (block_done_o)
				done_seen++;
			if (rd_valid_o && rd_ready_i)  // word transfers on the coming edge
			begin
				if (exp_q.size() == 0)
				begin
					word_errs++;
					$display("a word %h came out of the stream with none expected", rd_data_o);
				end
				else
					check_word(rd_data_o, exp_q.pop_front());
			end
		end
	end

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			flag_errs++;
			$display("FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
		begin
			flag_errs++;
			$display("FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	// one strobe with fresh samples and ticks, expected words queued if the group is taken
	task automatic send_group(input int ngroups, input bit first, input bit last,
		output bit refused);
		rx_buf_pkg::chan_samps_t s;
		logic [rx_buf_pkg::TICKS_BITS-1:0] t;
		int need;
		int room;
		for (int c = 0; c < rx_buf_pkg::RX_CHANS; c++)
		begin
			samp_rng = xorshift(samp_rng);
			s[c].i = samp_rng[23:0];
			samp_rng = xorshift(samp_rng);
			s[c].q = samp_rng[23:0];
		end
		samp_rng = xorshift(samp_rng);
		t[47:32] = samp_rng[15:0];
		samp_rng = xorshift(samp_rng);
		t[31:0] = samp_rng;
		need = ngroups * rx_buf_pkg::RX_CHANS * 3 + 4;  // whole block incl trailer
		room = rx_buf_pkg::RXBUF_DEPTH - exp_q.size();
		refused = first && (room < need);
		@(posedge adc_clk);
		nsamps_i <= rx_buf_pkg::nsamps_t'(ngroups);
		chan_samps_i <= s;
		ticks_i <= t;
		samp_avail_i <= 1'b1;
		@(posedge adc_clk);
		samp_avail_i <= 1'b0;
		if (!refused)
		begin
			for (int c = 0; c < rx_buf_pkg::RX_CHANS; c++)
			begin
				exp_q.push_back(s[c].i[23:8]);
				exp_q.push_back(s[c].q[23:8]);
				exp_q.push_back({s[c].i[7:0], s[c].q[7:0]});  // i low byte on top
			end
			if (last)
			begin
				exp_q.push_back(t[15:0]);  // ticks low word first
				exp_q.push_back(t[31:16]);
				exp_q.push_back(t[47:32]);
				exp_q.push_back(blocks_done[15:0]);
			end
		end
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		@(negedge adc_clk);
		while (!block_done_o && n < WAIT_LIMIT)
		begin
			@(negedge adc_clk);
			n++;
		end
		if (!block_done_o)
		begin
			wait_errs++;
			$display("timed out waiting for block_done_o");
		end
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < WAIT_LIMIT)
		begin
			@(negedge adc_clk);
			n++;
		end
		if (exp_q.size() != 0)
		begin
			wait_errs++;
			$display("timed out with %0d words still expected on the stream", exp_q.size());
		end
	endtask

	task automatic run_block(input int ngroups, output bit refused);
		for (int g = 0; g < ngroups; g++)
		begin
			send_group(ngroups, g == 0, g == ngroups - 1, refused);
			if (refused)
				return;  // only the first strobe can be refused
			if (g != ngroups - 1)
				repeat (STROBE_GAP) @(posedge adc_clk);
		end
		wait_done();
		blocks_done++;
		exp_done++;
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////
	initial
	begin
		bit refused;
		int tries;
		int asrt_errs;
		reset_bufs_A = 1'b1;
		samp_avail_i = 1'b0;
		chan_samps_i = '0;
		ticks_i = '0;
		nsamps_i = 8'd1;
		samp_rng = SEED;
		repeat (2) @(posedge adc_clk);
		reset_bufs_A <= 1'b0;
		@(negedge adc_clk);
		check_flag("rd_valid_o", rd_valid_o, 1'b0);
		check_flag("block_done_o", block_done_o, 1'b0);
		check_flag("overrun_o", overrun_o, 1'b0);

		// in order words, counter word 0 then 1
		rdy_mode = 0;
		run_block(2, refused);
		run_block(2, refused);
		wait_drained();
		check_flag("overrun_o", overrun_o, 1'b0);
		check_count("block_done_o pulses", done_seen, exp_done);

		// random back-pressure
		rdy_mode = 2;
		run_block(3, refused);
		run_block(1, refused);
		rdy_mode = 0;
		wait_drained();

		// reader stalled until a block no longer fits
		rdy_mode = 1;
		refused = 1'b0;
		tries = 0;
		while (!refused && tries < 8)
		begin
			run_block(20, refused);
			tries++;
		end
		if (!refused)
		begin
			wait_errs++;
			$display("no block was refused with the reader stalled");
		end
		repeat (STROBE_GAP) @(posedge adc_clk);
		@(negedge adc_clk);
		check_flag("overrun_o", overrun_o, 1'b1);
		check_count("block_done_o pulses", done_seen, exp_done);  // none for the refused one
		rdy_mode = 0;
		wait_drained();
		repeat (4) @(negedge adc_clk);
		check_flag("rd_valid_o", rd_valid_o, 1'b0);

		// reset in the middle of a block
		rdy_mode = 1;
		send_group(2, 1'b1, 1'b0, refused);
		repeat (STROBE_GAP) @(posedge adc_clk);
		reset_bufs_A <= 1'b1;
		repeat (2) @(posedge adc_clk);
		reset_bufs_A <= 1'b0;
		exp_q.delete();  // partial block is gone
		blocks_done = 0;
		@(negedge adc_clk);
		check_flag("rd_valid_o", rd_valid_o, 1'b0);
		check_flag("overrun_o", overrun_o, 1'b0);
		rdy_mode = 0;
		run_block(2, refused);  // counter word back at 0
		wait_drained();
		check_count("block_done_o pulses", done_seen, exp_done);

		asrt_errs = DUT.u_asserts.fail_cnt;
		$display("errors: stream words %0d, flags %0d, waits %0d, assertions %0d",
			word_errs, flag_errs, wait_errs, asrt_errs);
		if (word_errs + flag_errs + wait_errs + asrt_errs == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
common/rx_buf_pkg.sv
rx_buffer/rx_group_counter.sv
rx_buffer/rx_xfer_fsm.sv
rx_buffer/rx_word_select.sv
rx_buffer/rx_sample_ram.sv
design/rx_buffer_top.sv
dv/rx_buffer_asserts.sv
dv/tb_rx_buffer.sv

//--- run.sh
#!/bin/sh
# build the rx buffer testbench with verilator, run it and look for the pass line
# the error limit keeps the run going past failed assertions so the report still prints
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_rx_buffer -f src.f -o tb_rx_buffer &&
./obj_dir/tb_rx_buffer +verilator+error+limit+1000 | tee /dev/stderr |
grep -qx "Simulation passed" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
